/* files.f */
blit_pkg.sv
blit_cmd_fifo.sv
blit_cmd_sequencer.sv
blit_setup_regs.sv
blit_command_parser.sv
tb_blit_command_parser.sv

/* tb_blit_command_parser.sv */
`timescale 1ns/100ps

module tb_blit_command_parser;

    localparam int FIFO_AW        = 4;              // 15 usable slots
    localparam int NUM_TESTS      = 5;
    localparam int TEST_CYCLES    = 300;            // Queueing and overflow is the longest test
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES * 4;
    localparam int RNG_SEED       = 32'he82b_b919;

    logic                        clock;
    logic                        reset;
    logic                        blit_valid;
    logic [blit_pkg::WORD_W-1:0] blit_command;
    logic                        blit_priv;
    logic [FIFO_AW-1:0]          slots_free;
    blit_pkg::blit_job_t         job;
    blit_pkg::blit_setup_t       setup;
    logic                        start;
    logic                        ack;
    logic                        busy;

    blit_pkg::blit_job_t   jobs[$];                 // Captured by the core model at ack
    blit_pkg::blit_setup_t setups[$];
    blit_pkg::blit_setup_t exp_setup;
    logic [15:0]           off_x;
    logic [15:0]           off_y;
    logic                  core_hold;               // Keeps busy high after the next ack
    int                    errors;
    int                    tests_passed;
    int                    tests_failed;

    blit_command_parser #(.FIFO_AW(FIFO_AW)) DUT (
        .clock        (clock),
        .reset        (reset),
        .blit_valid   (blit_valid),
        .blit_command (blit_command),
        .blit_priv    (blit_priv),
        .slots_free   (slots_free),
        .job          (job),
        .setup        (setup),
        .start        (start),
        .ack          (ack),
        .busy         (busy)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Blitter core model with random ack delay and busy length
    initial begin : core_model
        int unsigned delay;
        int unsigned busy_len;
        logic        held;
        void'($urandom(RNG_SEED));
        ack  = 1'b0;
        busy = 1'b0;
        forever begin
            @(posedge clock);
            #10;
            if (start) begin
                delay = $urandom_range(4, 1);
                repeat (delay) @(posedge clock);
                #10;
                ack  = 1'b1;
                busy = 1'b1;
                held = core_hold;
                jobs.push_back(job);
                setups.push_back(setup);
                @(posedge clock);
                #10;
                ack      = 1'b0;
                busy_len = $urandom_range(20, 2);
                repeat (busy_len - 1) begin
                    @(posedge clock);
                    #10;
                end
                while (held && core_hold) begin
                    @(posedge clock);
                    #10;
                end
                busy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int unsigned cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
        $display("Regression failed");
        $finish;
    end

    task automatic step();
        @(posedge clock);
        #10;
    endtask

    task automatic write_word(logic [31:0] word, logic priv);
        blit_valid   = 1'b1;
        blit_command = word;
        blit_priv    = priv;
        step();
        blit_valid = 1'b0;
    endtask

    function automatic logic [31:0] xy(logic [15:0] x, logic [15:0] y);
        return {y, x};
    endfunction

    task automatic draw_rect(logic [7:0] color, logic [15:0] x1, logic [15:0] y1,
                             logic [15:0] x2, logic [15:0] y2);
        write_word({blit_pkg::DRAW_RECT, 16'h0000, color}, 1'b0);
        write_word(xy(x1, y1), 1'b0);
        write_word(xy(x2, y2), 1'b0);
    endtask

    task automatic copy_rect(logic [7:0] color, logic [15:0] x1, logic [15:0] y1,
                             logic [15:0] x2, logic [15:0] y2,
                             logic [15:0] sx, logic [15:0] sy);
        write_word({blit_pkg::COPY_RECT, 16'h0000, color}, 1'b0);
        write_word(xy(x1, y1), 1'b0);
        write_word(xy(x2, y2), 1'b0);
        write_word(xy(sx, sy), 1'b0);
    endtask

    function automatic blit_pkg::blit_job_t expect_job(
        blit_pkg::blit_op_t op, logic [7:0] color, logic [15:0] x1, logic [15:0] y1,
        logic [15:0] x2, logic [15:0] y2, logic [15:0] sx, logic [15:0] sy);
        blit_pkg::blit_job_t j;
        j       = '0;
        j.op    = op;
        j.color = color;
        j.x1    = x1 + off_x;       // Drawing offset moves every coordinate
        j.y1    = y1 + off_y;
        j.x2    = x2 + off_x;
        j.y2    = y2 + off_y;
        j.src_x = sx + off_x;
        j.src_y = sy + off_y;
        return j;
    endfunction

    task automatic check_hex(string name, logic [191:0] expected, logic [191:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_for_acks(int n);
        do @(negedge clock); while (jobs.size() < n);
        step();
    endtask

    // Compares the next recorded job and the setup seen with it
    task automatic check_ack(blit_pkg::blit_job_t exp_job, blit_pkg::blit_setup_t exp_set);
        blit_pkg::blit_job_t got;
        if (jobs.size() == 0) begin
            $display("A job was expected but the core model recorded none");
            errors++;
            return;
        end
        got = jobs.pop_front();
        check_hex("job.op", exp_job.op, got.op);
        check_hex("job.color", exp_job.color, got.color);
        check_hex("job.x1", exp_job.x1, got.x1);
        check_hex("job.y1", exp_job.y1, got.y1);
        check_hex("job.x2", exp_job.x2, got.x2);
        check_hex("job.y2", exp_job.y2, got.y2);
        if (exp_job.op == blit_pkg::BLIT_COPY) begin
            check_hex("job.src_x", exp_job.src_x, got.src_x);
            check_hex("job.src_y", exp_job.src_y, got.src_y);
        end
        check_hex("setup", exp_set, setups.pop_front());
    endtask

    task automatic check_quiet(string what);
        @(negedge clock);
        if (jobs.size() != 0 || start !== 1'b0) begin
            $display("The core was started by %s", what);
            errors++;
        end
        step();
    endtask

    task automatic set_hold(logic value);
        @(negedge clock);
        core_hold = value;
        step();
    endtask

    task automatic finish_test(string name, int start_errors);
        if (errors == start_errors) begin
            $display("%s: PASS", name);
            tests_passed++;
        end else begin
            $display("%s: FAIL with %0d errors", name, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic test_setup_and_rect();
        int start_errors;
        start_errors = errors;
        check_hex("slots_free", 15, slots_free);
        write_word({blit_pkg::SETUP, 8'h00, 16'h0140}, 1'b1);   // Dest stride
        write_word(32'hFDAB_CDEF, 1'b1);                         // Top 6 bits unused
        write_word(xy(4, 8), 1'b1);
        write_word(xy(300, 200), 1'b1);
        write_word(xy(10, 20), 1'b1);
        write_word(32'h0040_0000, 1'b1);
        write_word(32'h0000_0200, 1'b1);
        exp_setup.dest_stride = 16'h0140;
        exp_setup.dest_addr   = 26'h1AB_CDEF;
        exp_setup.clip_x1     = 16'd4;
        exp_setup.clip_y1     = 16'd8;
        exp_setup.clip_x2     = 16'd300;
        exp_setup.clip_y2     = 16'd200;
        off_x = 16'd10;
        off_y = 16'd20;
        draw_rect(8'h37, 5, 6, 50, 60);
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_RECT, 8'h37, 5, 6, 50, 60, 0, 0), exp_setup);
        copy_rect(8'h3C, 1, 1, 9, 9, 2, 2);                     // Makes the SETUP source live
        exp_setup.src_addr   = 26'h040_0000;
        exp_setup.src_stride = 16'h0200;
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_COPY, 8'h3C, 1, 1, 9, 9, 2, 2), exp_setup);
        finish_test("setup_and_rect", start_errors);
    endtask

    task automatic test_copy_and_src();
        int start_errors;
        start_errors = errors;
        write_word({blit_pkg::SET_SRC, 8'h00, 16'h0200}, 1'b1);
        write_word(32'h0055_0000, 1'b1);
        copy_rect(8'hA5, 1, 2, 33, 34, 100, 110);
        exp_setup.src_addr   = 26'h055_0000;
        exp_setup.src_stride = 16'h0200;
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_COPY, 8'hA5, 1, 2, 33, 34, 100, 110), exp_setup);
        write_word({blit_pkg::SET_SRC, 8'h00, 16'h0300}, 1'b1);
        write_word(32'h0066_0000, 1'b1);
        draw_rect(8'h11, 0, 0, 8, 8);                          // Source must not move yet
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_RECT, 8'h11, 0, 0, 8, 8, 0, 0), exp_setup);
        copy_rect(8'h22, 2, 3, 4, 5, 6, 7);
        exp_setup.src_addr   = 26'h066_0000;
        exp_setup.src_stride = 16'h0300;
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_COPY, 8'h22, 2, 3, 4, 5, 6, 7), exp_setup);
        finish_test("copy_and_src", start_errors);
    endtask

    task automatic test_privilege();
        int start_errors;
        int i;
        start_errors = errors;
        write_word({blit_pkg::SETUP, 8'h00, 16'h0999}, 1'b0);
        for (i = 0; i < 6; i++) begin
            write_word(32'h0000_1111 * (i + 1), 1'b0);         // Decoded as NOPs
        end
        write_word({blit_pkg::SET_SRC, 8'h00, 16'h0777}, 1'b0);
        write_word(32'h0000_2222, 1'b0);
        draw_rect(8'h5A, 7, 9, 70, 90);
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_RECT, 8'h5A, 7, 9, 70, 90, 0, 0), exp_setup);
        copy_rect(8'h5B, 2, 2, 6, 6, 1, 1);                    // Source stays as last committed
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_COPY, 8'h5B, 2, 2, 6, 6, 1, 1), exp_setup);
        finish_test("privilege", start_errors);
    endtask

    task automatic test_transparency_and_nop();
        int start_errors;
        start_errors = errors;
        check_hex("setup.transparent_color", 9'h100, setup.transparent_color);
        write_word({blit_pkg::SET_TRANSPARENCY, 8'h00, 16'hFE42}, 1'b0);
        write_word(32'h0000_0000, 1'b0);
        write_word(32'h7700_1234, 1'b0);                       // Unknown opcode
        repeat (40) step();
        check_quiet("a command that draws nothing");
        exp_setup.transparent_color = 9'h042;                  // Low 9 bits of 0xFE42
        draw_rect(8'h6C, 3, 4, 5, 6);
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_RECT, 8'h6C, 3, 4, 5, 6, 0, 0), exp_setup);
        finish_test("transparency_and_nop", start_errors);
    endtask

    task automatic test_queue_and_overflow();
        int start_errors;
        int i;
        start_errors = errors;
        set_hold(1'b1);
        draw_rect(8'h01, 1, 1, 11, 11);
        draw_rect(8'h02, 2, 2, 12, 12);
        draw_rect(8'h03, 3, 3, 13, 13);
        wait_for_acks(1);
        check_hex("slots_free", 9, slots_free);                // Two jobs still queued
        set_hold(1'b0);
        wait_for_acks(3);
        for (i = 1; i <= 3; i++) begin
            check_ack(expect_job(blit_pkg::BLIT_RECT, 8'(i), i, i, i + 10, i + 10, 0, 0),
                      exp_setup);
        end
        set_hold(1'b1);
        draw_rect(8'h04, 4, 4, 14, 14);
        wait_for_acks(1);
        check_ack(expect_job(blit_pkg::BLIT_RECT, 8'h04, 4, 4, 14, 14, 0, 0), exp_setup);
        for (i = 0; i < 5; i++) begin
            draw_rect(8'(8'h40 + i), i, i, i + 20, i + 20);
        end
        draw_rect(8'h50, 9, 9, 29, 29);                        // Last five words are dropped
        write_word({blit_pkg::DRAW_RECT, 16'h0000, 8'h51}, 1'b0);
        write_word(xy(1, 1), 1'b0);
        check_hex("slots_free", 0, slots_free);
        set_hold(1'b0);
        wait_for_acks(5);
        for (i = 0; i < 5; i++) begin
            check_ack(expect_job(blit_pkg::BLIT_RECT, 8'(8'h40 + i), i, i, i + 20, i + 20,
                                 0, 0), exp_setup);
        end
        repeat (40) step();
        check_quiet("words written into a full FIFO");
        check_hex("slots_free", 15, slots_free);
        finish_test("queue_and_overflow", start_errors);
    endtask

    initial begin
        reset        = 1'b1;
        blit_valid   = 1'b0;
        blit_command = '0;
        blit_priv    = 1'b0;
        core_hold    = 1'b0;
        off_x        = '0;
        off_y        = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        exp_setup    = '0;
        exp_setup.transparent_color = 9'h100;                 // Disabled out of reset
        repeat (8) @(posedge clock);
        #10;
        reset = 1'b0;
        step();

        test_setup_and_rect();
        test_copy_and_src();
        test_privilege();
        test_transparency_and_nop();
        test_queue_and_overflow();

        $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* blit_command_parser.sv */
`timescale 1ns/100ps

module blit_command_parser #(
    parameter int FIFO_AW = 10
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         blit_valid,   // Single-cycle write strobe
    input  logic [blit_pkg::WORD_W-1:0]  blit_command,
    input  logic                         blit_priv,    // Allows SETUP and SET_SRC
    output logic [FIFO_AW-1:0]           slots_free,
    output blit_pkg::blit_job_t          job,
    output blit_pkg::blit_setup_t        setup,
    output logic                         start,
    input  logic                         ack,
    input  logic                         busy
);

    blit_pkg::cmd_word_t           wr_data;
    blit_pkg::cmd_word_t           head;
    logic                          head_valid;
    logic                          pop;
    logic                          setup_wr;
    blit_pkg::setup_field_t        setup_sel;
    logic [blit_pkg::WORD_W-1:0]   setup_data;
    logic                          src_commit;
    logic [blit_pkg::COORD_W-1:0]  offset_x;
    logic [blit_pkg::COORD_W-1:0]  offset_y;

    assign wr_data = '{priv: blit_priv, word: blit_command};

    blit_cmd_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
        .clock      (clock),
        .reset      (reset),
        .wr         (blit_valid),
        .wr_data    (wr_data),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .slots_free (slots_free)
    );

    blit_cmd_sequencer u_sequencer (
        .clock      (clock),
        .reset      (reset),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop),
        .setup_wr   (setup_wr),
        .setup_sel  (setup_sel),
        .setup_data (setup_data),
        .src_commit (src_commit),
        .offset_x   (offset_x),
        .offset_y   (offset_y),
        .job        (job),
        .start      (start),
        .ack        (ack),
        .busy       (busy)
    );

    blit_setup_regs u_setup_regs (
        .clock      (clock),
        .reset      (reset),
        .setup_wr   (setup_wr),
        .setup_sel  (setup_sel),
        .setup_data (setup_data),
        .src_commit (src_commit),
        .setup      (setup),
        .offset_x   (offset_x),
        .offset_y   (offset_y)
    );

endmodule

/* blit_setup_regs.sv */
`timescale 1ns/100ps

module blit_setup_regs (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          setup_wr,
    input  blit_pkg::setup_field_t        setup_sel,
    input  logic [blit_pkg::WORD_W-1:0]   setup_data,
    input  logic                          src_commit,
    output blit_pkg::blit_setup_t         setup,
    output logic [blit_pkg::COORD_W-1:0]  offset_x,
    output logic [blit_pkg::COORD_W-1:0]  offset_y
);

    // Source registers written by software, applied at the next copy
    logic [blit_pkg::ADDR_W-1:0]   staged_src_addr;
    logic [blit_pkg::COORD_W-1:0]  staged_src_stride;

    logic [blit_pkg::COORD_W-1:0]  data_lo;
    logic [blit_pkg::COORD_W-1:0]  data_hi;

    assign data_lo = setup_data[blit_pkg::COORD_W-1:0];                    // X half
    assign data_hi = setup_data[blit_pkg::WORD_W-1 -: blit_pkg::COORD_W];  // Y half

    always_ff @(posedge clock) begin
        if (reset) begin
            setup                   <= '0;
            setup.transparent_color <= blit_pkg::TRANSPARENT_OFF;
            staged_src_addr         <= '0;
            staged_src_stride       <= '0;
            offset_x                <= '0;
            offset_y                <= '0;
        end else begin
            if (setup_wr) begin
                case (setup_sel)
                    blit_pkg::DEST_STRIDE: begin
                        setup.dest_stride <= data_lo;
                    end
                    blit_pkg::DEST_ADDR: begin
                        setup.dest_addr <= setup_data[blit_pkg::ADDR_W-1:0];
                    end
                    blit_pkg::CLIP_MIN: begin
                        setup.clip_x1 <= data_lo;
                        setup.clip_y1 <= data_hi;
                    end
                    blit_pkg::CLIP_MAX: begin
                        setup.clip_x2 <= data_lo;
                        setup.clip_y2 <= data_hi;
                    end
                    blit_pkg::OFFSET: begin
                        offset_x <= data_lo;
                        offset_y <= data_hi;
                    end
                    blit_pkg::SRC_ADDR: begin
                        staged_src_addr <= setup_data[blit_pkg::ADDR_W-1:0];
                    end
                    blit_pkg::SRC_STRIDE: begin
                        staged_src_stride <= data_lo;
                    end
                    blit_pkg::TRANSPARENT: begin
                        setup.transparent_color <= setup_data[blit_pkg::COLOR_W:0];
                    end
                    default: ;
                endcase
            end

            // Visible source only moves when a copy starts
            if (src_commit) begin
                setup.src_addr   <= staged_src_addr;
                setup.src_stride <= staged_src_stride;
            end
        end
    end

endmodule

/* blit_cmd_sequencer.sv */
`timescale 1ns/100ps

module blit_cmd_sequencer (
    input  logic                          clock,
    input  logic                          reset,
    input  blit_pkg::cmd_word_t           head,
    input  logic                          head_valid,
    output logic                          pop,
    output logic                          setup_wr,
    output blit_pkg::setup_field_t        setup_sel,
    output logic [blit_pkg::WORD_W-1:0]   setup_data,
    output logic                          src_commit,
    input  logic [blit_pkg::COORD_W-1:0]  offset_x,
    input  logic [blit_pkg::COORD_W-1:0]  offset_y,
    output blit_pkg::blit_job_t           job,
    output logic                          start,
    input  logic                          ack,
    input  logic                          busy
);

    typedef enum logic [2:0] {
        IDLE,
        RECT_ARGS,
        COPY_ARGS,
        SETUP_ARGS,
        SRC_ARGS,
        WAIT_ACK,
        WAIT_IDLE
    } state_t;

    state_t                        state;
    logic [2:0]                    arg_count;
    blit_pkg::blit_opcode_t        opcode;
    blit_pkg::setup_field_t        setup_order;
    logic [blit_pkg::COORD_W-1:0]  arg_x;
    logic [blit_pkg::COORD_W-1:0]  arg_y;

    assign opcode = blit_pkg::blit_opcode_t'(head.word[blit_pkg::WORD_W-1 -: blit_pkg::OPCODE_W]);

    // Coordinate pair with the drawing offset applied
    assign arg_x = head.word[blit_pkg::COORD_W-1:0] + offset_x;
    assign arg_y = head.word[blit_pkg::WORD_W-1 -: blit_pkg::COORD_W] + offset_y;

    // One word per cycle in every state that reads the FIFO
    assign pop = head_valid && (state inside {IDLE, RECT_ARGS, COPY_ARGS, SETUP_ARGS, SRC_ARGS});

    // Order of the SETUP parameter words
    always_comb begin
        case (arg_count)
            3'd0:    setup_order = blit_pkg::DEST_ADDR;
            3'd1:    setup_order = blit_pkg::CLIP_MIN;
            3'd2:    setup_order = blit_pkg::CLIP_MAX;
            3'd3:    setup_order = blit_pkg::OFFSET;
            3'd4:    setup_order = blit_pkg::SRC_ADDR;
            default: setup_order = blit_pkg::SRC_STRIDE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= IDLE;
            arg_count  <= 3'd0;
            start      <= 1'b0;
            setup_wr   <= 1'b0;
            setup_sel  <= blit_pkg::DEST_STRIDE;
            setup_data <= '0;
            src_commit <= 1'b0;
            job        <= '0;
        end else begin
            setup_wr   <= 1'b0;
            src_commit <= 1'b0;
            if (pop) begin
                setup_data <= head.word;  // Setup block picks its own bits
            end

            case (state)
                IDLE: begin
                    arg_count <= 3'd0;
                    if (head_valid) begin
                        case (opcode)
                            blit_pkg::DRAW_RECT: begin
                                job.color <= head.word[blit_pkg::COLOR_W-1:0];
                                state     <= RECT_ARGS;
                            end
                            blit_pkg::COPY_RECT: begin
                                job.color <= head.word[blit_pkg::COLOR_W-1:0];
                                state     <= COPY_ARGS;
                            end
                            blit_pkg::SET_TRANSPARENCY: begin
                                setup_wr  <= 1'b1;
                                setup_sel <= blit_pkg::TRANSPARENT;
                            end
                            blit_pkg::SETUP: begin
                                if (head.priv) begin  // Otherwise dropped like a NOP
                                    setup_wr  <= 1'b1;
                                    setup_sel <= blit_pkg::DEST_STRIDE;
                                    state     <= SETUP_ARGS;
                                end
                            end
                            blit_pkg::SET_SRC: begin
                                if (head.priv) begin
                                    setup_wr  <= 1'b1;
                                    setup_sel <= blit_pkg::SRC_STRIDE;
                                    state     <= SRC_ARGS;
                                end
                            end
                            default: ;                // NOP and unknown opcodes
                        endcase
                    end
                end

                RECT_ARGS: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        if (arg_count == 3'd0) begin
                            job.x1 <= arg_x;
                            job.y1 <= arg_y;
                        end else begin
                            job.x2 <= arg_x;
                            job.y2 <= arg_y;
                            job.op <= blit_pkg::BLIT_RECT;
                            start  <= 1'b1;
                            state  <= WAIT_ACK;
                        end
                    end
                end

                COPY_ARGS: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        case (arg_count)
                            3'd0: begin
                                job.x1 <= arg_x;
                                job.y1 <= arg_y;
                            end
                            3'd1: begin
                                job.x2 <= arg_x;
                                job.y2 <= arg_y;
                            end
                            default: begin
                                job.src_x  <= arg_x;
                                job.src_y  <= arg_y;
                                job.op     <= blit_pkg::BLIT_COPY;
                                start      <= 1'b1;
                                src_commit <= 1'b1;   // Staged source goes live
                                state      <= WAIT_ACK;
                            end
                        endcase
                    end
                end

                SETUP_ARGS: begin
                    if (head_valid) begin
                        arg_count <= arg_count + 3'd1;
                        setup_wr  <= 1'b1;
                        setup_sel <= setup_order;
                        if (arg_count == 3'd5) begin
                            state <= IDLE;
                        end
                    end
                end

                SRC_ARGS: begin
                    if (head_valid) begin
                        setup_wr  <= 1'b1;
                        setup_sel <= blit_pkg::SRC_ADDR;
                        state     <= IDLE;
                    end
                end

                WAIT_ACK: begin
                    start <= !ack;                    // Drops the cycle after ack
                    if (ack) begin
                        state <= WAIT_IDLE;
                    end
                end

                WAIT_IDLE: begin
                    if (!busy) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* blit_cmd_fifo.sv */
`timescale 1ns/100ps

module blit_cmd_fifo #(
    parameter int FIFO_AW = 10
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                wr,
    input  blit_pkg::cmd_word_t wr_data,
    input  logic                pop,
    output blit_pkg::cmd_word_t head,
    output logic                head_valid,
    output logic [FIFO_AW-1:0]  slots_free
);

    localparam int DEPTH = 2 ** FIFO_AW;

    blit_pkg::cmd_word_t mem [DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW-1:0] next_wr_ptr;
    logic [FIFO_AW-1:0] next_rd_ptr;
    logic               full;
    logic               wr_ok;
    logic               pop_ok;

    // One slot always stays empty so full and empty differ
    assign full   = (wr_ptr + FIFO_AW'(1)) == rd_ptr;
    assign wr_ok  = wr && !full;          // Strobe into a full FIFO is lost
    assign pop_ok = pop && head_valid;

    assign next_wr_ptr = wr_ptr + FIFO_AW'(wr_ok);
    assign next_rd_ptr = rd_ptr + FIFO_AW'(pop_ok);

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
        head <= mem[next_rd_ptr];         // Show-ahead read port
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            head_valid <= 1'b0;
            slots_free <= '1;             // DEPTH - 1 usable slots
        end else begin
            wr_ptr <= next_wr_ptr;
            rd_ptr <= next_rd_ptr;

            // The slot being written this cycle is not yet readable
            head_valid <= next_rd_ptr != wr_ptr;

            slots_free <= next_rd_ptr - next_wr_ptr - FIFO_AW'(1);
        end
    end

endmodule

/* blit_pkg.sv */
package blit_pkg;

    localparam int COORD_W  = 16;   // Coordinates, strides and offsets
    localparam int ADDR_W   = 26;   // Bitmap byte address
    localparam int WORD_W   = 32;   // Command word
    localparam int COLOR_W  = 8;
    localparam int OPCODE_W = 8;    // Top byte of a command word

    // Top bit set turns the transparency test off
    localparam logic [COLOR_W:0] TRANSPARENT_OFF = {1'b1, {COLOR_W{1'b0}}};

    // One FIFO entry, privilege tag above the command word
    typedef struct packed {
        logic              priv;
        logic [WORD_W-1:0] word;
    } cmd_word_t;

    typedef enum logic [OPCODE_W-1:0] {
        NOP              = 8'h00,
        DRAW_RECT        = 8'h01,   // (color) (x1/y1) (x2/y2)
        COPY_RECT        = 8'h02,   // (color) (x1/y1) (x2/y2) (src_x/src_y)
        SET_TRANSPARENCY = 8'h04,   // (transparent_color)
        SET_SRC          = 8'hFE,   // (src_stride) (src_addr), privileged
        SETUP            = 8'hFF    // (dest_stride) plus six words, privileged
    } blit_opcode_t;

    typedef enum logic [1:0] {
        BLIT_RECT = 2'd0,
        BLIT_COPY = 2'd1
    } blit_op_t;

    typedef enum logic [2:0] {
        DEST_STRIDE,
        DEST_ADDR,
        CLIP_MIN,
        CLIP_MAX,
        OFFSET,
        SRC_ADDR,
        SRC_STRIDE,
        TRANSPARENT
    } setup_field_t;

    typedef struct packed {
        blit_op_t           op;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y1;
        logic [COORD_W-1:0] x2;     // Exclusive
        logic [COORD_W-1:0] y2;     // Exclusive
        logic [COORD_W-1:0] src_x;
        logic [COORD_W-1:0] src_y;
        logic [COLOR_W-1:0] color;
    } blit_job_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  dest_addr;
        logic [COORD_W-1:0] dest_stride;
        logic [ADDR_W-1:0]  src_addr;
        logic [COORD_W-1:0] src_stride;
        logic [COORD_W-1:0] clip_x1;
        logic [COORD_W-1:0] clip_y1;
        logic [COORD_W-1:0] clip_x2;
        logic [COORD_W-1:0] clip_y2;
        logic [COLOR_W:0]   transparent_color;
    } blit_setup_t;

endpackage
